// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pcs_rx_tb \
    -f sources.f --Mdir obj_dir -o pcs_rx_sim

./obj_dir/pcs_rx_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: sources.f
src/pcs_rx_pkg.sv
src/block_classifier.sv
src/frame_fsm.sv
src/errd_blk_counter.sv
src/beat_output_stage.sv
src/pcs_rx_top.sv
tb/tb_clock_gen.sv
tb/pcs_rx_checker.sv
tb/pcs_rx_tb.sv

// File: src/beat_output_stage.sv
/*
 * Output beat register.
 * Captures the four lane payloads and the lane marks of a beat,
 * with the marks and valid bit forced low in empty cycles.
 */
`timescale 1ns/1ns

module beat_output_stage (
    input  logic                                              clk_156,
    input  logic                                              async_reset_n,
    input  logic                                              valid_i,
    input  pcs_rx_pkg::lane_marks_t                           marks_i,
    input  pcs_rx_pkg::pcs_block_t [pcs_rx_pkg::NUM_LANES-1:0] blocks_i,
    output pcs_rx_pkg::rx_beat_t                              beat_o
);

    import pcs_rx_pkg::*;

    rx_beat_t beat_d;

    always_comb begin
        beat_d.valid = valid_i;

        if (valid_i) begin
            beat_d.marks = marks_i;
        end else begin
            beat_d.marks = '0;
        end

        // Sync headers are not part of the beat
        for (int i = 0; i < NUM_LANES; i++) begin
            beat_d.payload[i] = blocks_i[i].payload;
        end
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            beat_o <= '0;
        end else begin
            beat_o <= beat_d;
        end
    end

endmodule

// File: src/block_classifier.sv
/*
 * Single lane 66-bit block decoder.
 * Sorts a block into data, start, terminate, idle or error
 * and gives the frame byte count of a terminate block.
 */
`timescale 1ns/1ns

module block_classifier (
    input  pcs_rx_pkg::pcs_block_t  block_i,
    output pcs_rx_pkg::blk_kind_t   kind_o,
    output pcs_rx_pkg::term_bytes_t term_bytes_o
);

    import pcs_rx_pkg::*;

    logic [7:0] type_byte;

    assign type_byte = block_i.payload[7:0];

    always_comb begin
        kind_o       = BLK_ERROR;
        term_bytes_o = '0;

        if (block_i.hdr == SYNC_DATA) begin
            kind_o = BLK_DATA;
        end else if (block_i.hdr == SYNC_CTRL) begin
            // Terminate code n carries n frame bytes
            case (type_byte)
                BT_START:  kind_o = BLK_START;
                BT_IDLE:   kind_o = BLK_IDLE;
                BT_TERM_0: kind_o = BLK_TERM;
                BT_TERM_1: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd1;
                end
                BT_TERM_2: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd2;
                end
                BT_TERM_3: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd3;
                end
                BT_TERM_4: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd4;
                end
                BT_TERM_5: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd5;
                end
                BT_TERM_6: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd6;
                end
                BT_TERM_7: begin
                    kind_o       = BLK_TERM;
                    term_bytes_o = 3'd7;
                end
                default:   kind_o = BLK_ERROR;
            endcase
        end
    end

endmodule

// File: src/errd_blk_counter.sv
/*
 * Saturating errored block counter.
 * Adds the error events of each beat, holds at the maximum,
 * and returns to zero on a clear pulse.
 */
`timescale 1ns/1ns

module errd_blk_counter (
    input  logic                    clk_156,
    input  logic                    async_reset_n,
    input  logic                    clear_i,
    input  pcs_rx_pkg::err_events_t events_i,
    output pcs_rx_pkg::err_cnt_t    count_o
);

    import pcs_rx_pkg::*;

    logic [$bits(err_cnt_t):0] sum;
    err_cnt_t                  count_d;

    assign sum = {1'b0, count_o} + {{($bits(err_cnt_t) - $bits(err_events_t) + 1){1'b0}}, events_i};

    always_comb begin
        if (sum > {1'b0, ERR_CNT_MAX}) begin
            count_d = ERR_CNT_MAX;
        end else begin
            count_d = sum[$bits(err_cnt_t)-1:0];
        end
    end

    // Clear wins over the events of the same beat
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else begin
            count_o <= count_d;
        end
    end

endmodule

// File: src/frame_fsm.sv
/*
 * Frame state machine over the four lanes of a beat.
 * Walks lanes 0 to 3 in one pass, marks payload lanes, start and
 * end of frame, and counts blocks that break the framing rules.
 */
`timescale 1ns/1ns

module frame_fsm (
    input  logic                                               clk_156,
    input  logic                                               async_reset_n,
    input  logic                                               valid_i,
    input  pcs_rx_pkg::blk_kind_t   [pcs_rx_pkg::NUM_LANES-1:0] kinds_i,
    input  pcs_rx_pkg::term_bytes_t [pcs_rx_pkg::NUM_LANES-1:0] term_bytes_i,
    output pcs_rx_pkg::lane_marks_t                            marks_o,
    output pcs_rx_pkg::err_events_t                            err_events_o
);

    import pcs_rx_pkg::*;

    frame_state_t state_q;
    frame_state_t state_d;

    //////////////////////////////
    // Lane walk
    //////////////////////////////
    always_comb begin
        frame_state_t walk;

        walk         = state_q;
        marks_o      = '0;
        err_events_o = '0;

        if (valid_i) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                case (kinds_i[i])
                    BLK_START: begin
                        // Start inside a frame aborts the old one
                        if (walk == FRAME_ACTIVE) begin
                            marks_o.err  = 1'b1;
                            err_events_o = err_events_o + 3'd1;
                        end
                        marks_o.sop      = 1'b1;
                        marks_o.sop_lane = lane_idx_t'(i);
                        walk             = FRAME_ACTIVE;
                    end
                    BLK_DATA: begin
                        if (walk == FRAME_ACTIVE) begin
                            marks_o.lane_valid[i] = 1'b1;
                        end else begin
                            marks_o.err  = 1'b1;
                            err_events_o = err_events_o + 3'd1;
                        end
                    end
                    BLK_TERM: begin
                        if (walk == FRAME_ACTIVE) begin
                            marks_o.lane_valid[i] = 1'b1;
                            marks_o.eop           = 1'b1;
                            marks_o.eop_lane      = lane_idx_t'(i);
                            marks_o.eop_bytes     = term_bytes_i[i];
                            walk                  = FRAME_IDLE;
                        end else begin
                            marks_o.err  = 1'b1;
                            err_events_o = err_events_o + 3'd1;
                        end
                    end
                    BLK_IDLE: begin
                        if (walk == FRAME_ACTIVE) begin
                            marks_o.err  = 1'b1;
                            err_events_o = err_events_o + 3'd1;
                            walk         = FRAME_IDLE;
                        end
                    end
                    default: begin
                        // Error block, aborts any open frame
                        marks_o.err  = 1'b1;
                        err_events_o = err_events_o + 3'd1;
                        walk         = FRAME_IDLE;
                    end
                endcase
            end
        end

        state_d = walk;
    end

    //////////////////////////////
    // State register
    //////////////////////////////
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            state_q <= FRAME_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: src/pcs_rx_pkg.sv
/*
 * Shared definitions for the four-lane 64b/66b receive delineator.
 * Sync header and block type codes, meaningful widths, the block kind
 * and frame state enums, and the block, lane mark and beat structs.
 */
package pcs_rx_pkg;

    localparam int NUM_LANES = 4;

    typedef logic [1:0]  sync_hdr_t;
    typedef logic [63:0] blk_payload_t;
    typedef logic [2:0]  term_bytes_t;
    typedef logic [7:0]  err_cnt_t;
    typedef logic [1:0]  lane_idx_t;
    typedef logic [2:0]  err_events_t;

    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    // Control block type byte, lowest payload byte
    localparam logic [7:0] BT_START  = 8'h78;
    localparam logic [7:0] BT_IDLE   = 8'h1E;
    localparam logic [7:0] BT_TERM_0 = 8'h87;
    localparam logic [7:0] BT_TERM_1 = 8'h99;
    localparam logic [7:0] BT_TERM_2 = 8'hAA;
    localparam logic [7:0] BT_TERM_3 = 8'hB4;
    localparam logic [7:0] BT_TERM_4 = 8'hCC;
    localparam logic [7:0] BT_TERM_5 = 8'hD2;
    localparam logic [7:0] BT_TERM_6 = 8'hE1;
    localparam logic [7:0] BT_TERM_7 = 8'hFF;

    localparam err_cnt_t ERR_CNT_MAX = 8'hFF;

    typedef enum logic [2:0] {
        BLK_DATA,
        BLK_START,
        BLK_TERM,
        BLK_IDLE,
        BLK_ERROR
    } blk_kind_t;

    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

    typedef struct packed {
        sync_hdr_t    hdr;
        blk_payload_t payload;
    } pcs_block_t;

    typedef struct packed {
        logic [NUM_LANES-1:0] lane_valid;
        logic                 sop;
        lane_idx_t            sop_lane;
        logic                 eop;
        lane_idx_t            eop_lane;
        term_bytes_t          eop_bytes;
        logic                 err;
    } lane_marks_t;

    typedef struct packed {
        logic                          valid;
        lane_marks_t                   marks;
        blk_payload_t [NUM_LANES-1:0]  payload;
    } rx_beat_t;

endpackage

// File: src/pcs_rx_top.sv
/*
 * Receive frame delineator top level.
 * Four lane classifiers, the frame state machine, the errored
 * block counter and the output beat register.
 */
`timescale 1ns/1ns

module pcs_rx_top (
    input  logic                                              clk_156,
    input  logic                                              async_reset_n,
    input  pcs_rx_pkg::pcs_block_t [pcs_rx_pkg::NUM_LANES-1:0] rx_blocks_i,
    input  logic                                              rx_valid_i,
    input  logic                                              clear_errblk_i,
    output pcs_rx_pkg::rx_beat_t                              rx_beat_o,
    output pcs_rx_pkg::err_cnt_t                              errd_blks_o
);

    import pcs_rx_pkg::*;

    blk_kind_t   [NUM_LANES-1:0] lane_kinds;
    term_bytes_t [NUM_LANES-1:0] lane_term_bytes;
    lane_marks_t                 lane_marks;
    err_events_t                 err_events;

    // Lane 0 is first in time
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        block_classifier block_classifier_i (
            .block_i      (rx_blocks_i[g]),
            .kind_o       (lane_kinds[g]),
            .term_bytes_o (lane_term_bytes[g])
        );
    end

    frame_fsm frame_fsm_i (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .valid_i       (rx_valid_i),
        .kinds_i       (lane_kinds),
        .term_bytes_i  (lane_term_bytes),
        .marks_o       (lane_marks),
        .err_events_o  (err_events)
    );

    errd_blk_counter errd_blk_counter_i (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .clear_i       (clear_errblk_i),
        .events_i      (err_events),
        .count_o       (errd_blks_o)
    );

    beat_output_stage beat_output_stage_i (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .valid_i       (rx_valid_i),
        .marks_i       (lane_marks),
        .blocks_i      (rx_blocks_i),
        .beat_o        (rx_beat_o)
    );

endmodule

// File: tb/pcs_rx_checker.sv
/*
 * Concurrent assertions on the delineator top-level ports.
 * Marks only with a valid beat, monotonic errored block count
 * between clears, and empty marks after an idle input cycle.
 */
`timescale 1ns/1ns

module pcs_rx_checker (
    input logic                 clk_156,
    input logic                 async_reset_n,
    input logic                 rx_valid_i,
    input logic                 clear_errblk_i,
    input pcs_rx_pkg::rx_beat_t rx_beat_i,
    input pcs_rx_pkg::err_cnt_t errd_blks_i
);

    sop_eop_need_valid: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        (rx_beat_i.marks.sop || rx_beat_i.marks.eop) |-> rx_beat_i.valid)
        else $error("sop or eop seen on a beat without its valid bit");

    // Only a clear may bring the count down
    count_no_decrease: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        !$past(clear_errblk_i) |-> (errd_blks_i >= $past(errd_blks_i)))
        else $error("errored block count went down without a clear");

    marks_empty_after_gap: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        !rx_valid_i |=> (rx_beat_i.marks == '0 && !rx_beat_i.valid))
        else $error("beat after an empty input cycle carries marks");

endmodule

bind pcs_rx_top pcs_rx_checker pcs_rx_checker_i (
    .clk_156        (clk_156),
    .async_reset_n  (async_reset_n),
    .rx_valid_i     (rx_valid_i),
    .clear_errblk_i (clear_errblk_i),
    .rx_beat_i      (rx_beat_o),
    .errd_blks_i    (errd_blks_o)
);

// File: tb/pcs_rx_tb.sv
/*
 * Directed testbench for the receive frame delineator.
 * Reset, framing, error, counter and gap tests, a watchdog,
 * and the final pass or fail report.
 */
`timescale 1ns/1ns

module pcs_rx_tb;

    import pcs_rx_pkg::*;

    typedef pcs_block_t [NUM_LANES-1:0] lane_blocks_t;

    localparam int  RESET_CYCLES = 16;
    localparam int  TEST_CYCLES  = 150;
    localparam int  MARGIN       = 50;
    localparam time CLK_PERIOD   = 40ns;
    // Lane codes that are not block types
    localparam logic [7:0] CODE_DATA = 8'h00;
    localparam logic [7:0] CODE_BAD  = 8'h01;

    logic         clk_156;
    logic         async_reset_n;
    lane_blocks_t rx_blocks_i;
    logic         rx_valid_i;
    logic         clear_errblk_i;
    rx_beat_t     rx_beat_o;
    err_cnt_t     errd_blks_o;

    integer       seed;
    rx_beat_t     obs_beat;
    err_cnt_t     obs_cnt;
    lane_blocks_t prev_blocks;
    err_cnt_t     exp_cnt;

    tb_clock_gen tb_clock_gen_i (.clk_o(clk_156));

    pcs_rx_top pcs_rx_top_i (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .rx_blocks_i    (rx_blocks_i),
        .rx_valid_i     (rx_valid_i),
        .clear_errblk_i (clear_errblk_i),
        .rx_beat_o      (rx_beat_o),
        .errd_blks_o    (errd_blks_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////
    function automatic pcs_block_t code_block(input logic [7:0] code);
        pcs_block_t blk;
        blk.payload = {$random(seed), $random(seed)};
        if (code == CODE_DATA) begin
            blk.hdr = SYNC_DATA;
        end else if (code == CODE_BAD) begin
            blk.hdr = 2'b11;
        end else begin
            blk.hdr          = SYNC_CTRL;
            blk.payload[7:0] = code;
        end
        return blk;
    endfunction

    // Arguments in lane order, lane 0 first
    function automatic lane_blocks_t make_beat(input logic [7:0] c0, c1, c2, c3);
        lane_blocks_t blks;
        blks[0] = code_block(c0);
        blks[1] = code_block(c1);
        blks[2] = code_block(c2);
        blks[3] = code_block(c3);
        return blks;
    endfunction

    function automatic lane_marks_t make_marks(input logic [3:0] mask, input logic sop,
            input lane_idx_t sop_lane, input logic eop, input lane_idx_t eop_lane,
            input term_bytes_t eop_bytes, input logic err);
        return '{mask, sop, sop_lane, eop, eop_lane, eop_bytes, err};
    endfunction

    function automatic err_cnt_t add_events(input err_cnt_t cnt, input int n);
        int sum;
        sum = int'(cnt) + n;
        return (sum > 255) ? 8'hFF : sum[7:0];
    endfunction

    // Samples the result of the previous beat, then drives the next one
    task automatic send_beat(input lane_blocks_t blks, input logic valid, input logic clear);
        @(posedge clk_156);
        #1;
        obs_beat    = rx_beat_o;
        obs_cnt     = errd_blks_o;
        prev_blocks = rx_blocks_i;
        #1;
        rx_blocks_i    = blks;
        rx_valid_i     = valid;
        clear_errblk_i = clear;
    endtask

    task automatic send_gap();
        send_beat(make_beat(BT_IDLE, BT_IDLE, BT_IDLE, BT_IDLE), 1'b0, 1'b0);
    endtask

    task automatic check_beat(input logic exp_valid, input lane_marks_t exp_marks);
        assert (obs_beat.valid == exp_valid) else report_failure($sformatf(
            "FAILED rx_beat_o.valid expected %h got %h", exp_valid, obs_beat.valid));
        assert (obs_beat.marks == exp_marks) else report_failure($sformatf(
            "FAILED rx_beat_o.marks expected %h got %h", exp_marks, obs_beat.marks));
        for (int i = 0; i < NUM_LANES; i++) begin
            assert (!exp_valid || obs_beat.payload[i] == prev_blocks[i].payload)
                else report_failure($sformatf("FAILED rx_beat_o.payload[%0d] expected %h got %h",
                    i, prev_blocks[i].payload, obs_beat.payload[i]));
        end
        assert (obs_cnt == exp_cnt) else report_failure($sformatf(
            "FAILED errd_blks_o expected %h got %h", exp_cnt, obs_cnt));
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    // Sampled before the first clock edge after reset release
    task automatic test_reset_values();
        obs_beat = rx_beat_o;
        obs_cnt  = errd_blks_o;
        assert (obs_beat == '0) else report_failure($sformatf(
            "FAILED rx_beat_o expected %h got %h", rx_beat_t'('0), obs_beat));
        check_beat(1'b0, '0);
    endtask

    task automatic test_single_beat_frame();
        send_beat(make_beat(BT_START, CODE_DATA, CODE_DATA, BT_TERM_3), 1'b1, 1'b0);
        send_gap();
        check_beat(1'b1, make_marks(4'b1110, 1'b1, 2'd0, 1'b1, 2'd3, 3'd3, 1'b0));
    endtask

    task automatic test_multi_beat_frame();
        send_beat(make_beat(BT_IDLE, BT_IDLE, BT_START, CODE_DATA), 1'b1, 1'b0);
        send_beat(make_beat(CODE_DATA, CODE_DATA, CODE_DATA, CODE_DATA), 1'b1, 1'b0);
        check_beat(1'b1, make_marks(4'b1000, 1'b1, 2'd2, 1'b0, 2'd0, 3'd0, 1'b0));
        send_beat(make_beat(CODE_DATA, BT_TERM_5, BT_IDLE, BT_IDLE), 1'b1, 1'b0);
        check_beat(1'b1, make_marks(4'b1111, 1'b0, 2'd0, 1'b0, 2'd0, 3'd0, 1'b0));
        send_gap();
        check_beat(1'b1, make_marks(4'b0011, 1'b0, 2'd0, 1'b1, 2'd1, 3'd5, 1'b0));
    endtask

    task automatic test_framing_errors();
        // Data with no frame open
        send_beat(make_beat(BT_IDLE, CODE_DATA, BT_IDLE, BT_IDLE), 1'b1, 1'b0);
        send_gap();
        exp_cnt = add_events(exp_cnt, 1);
        check_beat(1'b1, make_marks(4'b0000, 1'b0, 2'd0, 1'b0, 2'd0, 3'd0, 1'b1));
        // Idle inside a frame
        send_beat(make_beat(BT_START, CODE_DATA, BT_IDLE, BT_IDLE), 1'b1, 1'b0);
        send_gap();
        exp_cnt = add_events(exp_cnt, 1);
        check_beat(1'b1, make_marks(4'b0010, 1'b1, 2'd0, 1'b0, 2'd0, 3'd0, 1'b1));
        // Start while a frame from the previous beat is open
        send_beat(make_beat(BT_IDLE, BT_IDLE, BT_START, CODE_DATA), 1'b1, 1'b0);
        send_beat(make_beat(CODE_DATA, BT_START, CODE_DATA, BT_TERM_0), 1'b1, 1'b0);
        check_beat(1'b1, make_marks(4'b1000, 1'b1, 2'd2, 1'b0, 2'd0, 3'd0, 1'b0));
        send_gap();
        exp_cnt = add_events(exp_cnt, 1);
        check_beat(1'b1, make_marks(4'b1101, 1'b1, 2'd1, 1'b1, 2'd3, 3'd0, 1'b1));
        // Invalid sync header
        send_beat(make_beat(BT_START, CODE_DATA, CODE_BAD, BT_IDLE), 1'b1, 1'b0);
        send_gap();
        exp_cnt = add_events(exp_cnt, 1);
        check_beat(1'b1, make_marks(4'b0010, 1'b1, 2'd0, 1'b0, 2'd0, 3'd0, 1'b1));
    endtask

    task automatic test_counter();
        lane_marks_t err_marks;
        err_marks = make_marks(4'b0000, 1'b0, 2'd0, 1'b0, 2'd0, 3'd0, 1'b1);
        for (int n = 0; n < 70; n++) begin
            send_beat(make_beat(CODE_BAD, CODE_BAD, CODE_BAD, CODE_BAD), 1'b1, 1'b0);
        end
        send_gap();
        exp_cnt = add_events(exp_cnt, 4 * 70);
        check_beat(1'b1, err_marks);
        // Errors of the clearing beat are dropped
        send_beat(make_beat(CODE_BAD, CODE_BAD, CODE_BAD, CODE_BAD), 1'b1, 1'b1);
        send_gap();
        exp_cnt = '0;
        check_beat(1'b1, err_marks);
        send_gap();
        check_beat(1'b0, '0);
    endtask

    task automatic test_input_gaps();
        send_beat(make_beat(BT_IDLE, BT_IDLE, BT_IDLE, BT_START), 1'b1, 1'b0);
        send_gap();
        check_beat(1'b1, make_marks(4'b0000, 1'b1, 2'd3, 1'b0, 2'd0, 3'd0, 1'b0));
        send_gap();
        check_beat(1'b0, '0);
        send_beat(make_beat(CODE_DATA, CODE_DATA, CODE_DATA, CODE_DATA), 1'b1, 1'b0);
        check_beat(1'b0, '0);
        send_gap();
        check_beat(1'b1, make_marks(4'b1111, 1'b0, 2'd0, 1'b0, 2'd0, 3'd0, 1'b0));
        send_beat(make_beat(BT_TERM_2, BT_IDLE, BT_IDLE, BT_IDLE), 1'b1, 1'b0);
        check_beat(1'b0, '0);
        send_gap();
        check_beat(1'b1, make_marks(4'b0001, 1'b0, 2'd0, 1'b1, 2'd0, 3'd2, 1'b0));
    endtask

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
        report_failure("Watchdog timeout, the tests did not complete in time");
    end

    initial begin
        seed           = 32'h0a5f06d0;
        exp_cnt        = '0;
        async_reset_n  = 1'b0;
        rx_blocks_i    = '0;
        rx_valid_i     = 1'b0;
        clear_errblk_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_156);
        #2;
        async_reset_n = 1'b1;

        test_reset_values();
        test_single_beat_frame();
        test_multi_beat_frame();
        test_framing_errors();
        test_counter();
        test_input_gaps();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
/*
 * Free running clk_156 source for the testbench, 40 ns period.
 */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o
);

    localparam time HALF_PERIOD = 20ns;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule
